// ==== Makefile ====
# Verilator build and run of the decode/execute slice testbench

OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f all.f --top-module decexec_tb \
		-Mdir $(OBJ) -o decexec_tb

# $fatal gives a non-zero exit status, so make fails with it
run: compile
	./$(OBJ)/decexec_tb

clean:
	rm -rf $(OBJ)

// ==== all.f ====
+incdir+include
src/rvIsaPkg.sv
src/rvCtrlPkg.sv
src/maindecode.sv
src/aludecode.sv
src/immgen.sv
src/regfile.sv
src/alu.sv
src/decexec.sv
sim/decexec_tb.sv

// ==== include/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// RV32I widths, fixed by the ISA

`define RV_XLEN    32  // Data, address and PC width
`define RV_REGADDR 5   // Register index width
`define RV_NREGS   32  // x0 to x31

`endif

// ==== sim/decexec_tb.sv ====
module decexec_tb
    import rvIsaPkg::*, rvCtrlPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic    clk;
    logic    rst;
    logic    validD;
    instrT   instrD;
    wordT    pcD;
    logic    validW;
    regAddrT rdW;
    logic    regWriteW;
    wordT    resultW;
    logic    takenW;
    wordT    targetW;

    // One instruction per row with its hand-derived outcome
    typedef struct {
        instrT   instr;
        wordT    pc;
        logic    we;      // Expected regWriteW
        regAddrT rd;
        wordT    result;
        logic    taken;
        wordT    target;
    } rowT;

    rowT rows[$];

    decexec u_decexec (.clk, .rst, .validD, .instrD, .pcD, .validW, .rdW, .regWriteW,
                       .resultW, .takenW, .targetW);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // Small RV32I assembler for the table
    function automatic instrT rFormat(logic [6:0] f7, regAddrT rs2, regAddrT rs1,
                                      funct3T f3, regAddrT rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instrT iFormat(int imm, regAddrT rs1, funct3T f3, regAddrT rd,
                                      opcodeE opc = OPC_OPIMM);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic instrT bFormat(int imm, regAddrT rs2, regAddrT rs1, funct3T f3);
        logic [12:0] b;
        b = imm[12:0];  // Byte offset, bit 0 dropped by the format
        return {b[12], b[10:5], rs2, rs1, f3, b[4:1], b[11], OPC_BRANCH};
    endfunction

    function automatic instrT jFormat(int imm, regAddrT rd);
        logic [20:0] j;
        j = imm[20:0];
        return {j[20], j[10:1], j[11], j[19:12], rd, OPC_JAL};
    endfunction

    function automatic instrT uFormat(logic [19:0] imm, regAddrT rd, opcodeE opc);
        return {imm, rd, opc};
    endfunction

    task automatic addRow(instrT instr, wordT pc, logic we, regAddrT rd, wordT result,
                          logic taken = 1'b0, wordT target = '0);
        rowT r;
        r.instr  = instr;
        r.pc     = pc;
        r.we     = we;
        r.rd     = rd;
        r.result = result;
        r.taken  = taken;
        r.target = target;
        rows.push_back(r);
    endtask

    // Register state: x1=100, x2=-7, x3=3, x4=2047
    task automatic loadTable();
        addRow(rFormat(7'h00, 5'd31, 5'd30, 3'd0, 5'd29), 32'h100, 1'b1, 5'd29, 32'h0);
        addRow(iFormat(100, 5'd0, 3'd0, 5'd1), 32'h104, 1'b1, 5'd1, 32'h64);
        addRow(iFormat(-7, 5'd0, 3'd0, 5'd2), 32'h108, 1'b1, 5'd2, 32'hfffffff9);
        addRow(iFormat(3, 5'd0, 3'd0, 5'd3), 32'h10c, 1'b1, 5'd3, 32'h3);
        addRow(iFormat(2047, 5'd0, 3'd0, 5'd4), 32'h110, 1'b1, 5'd4, 32'h7ff);
        addRow(rFormat(7'h00, 5'd2, 5'd1, 3'd0, 5'd10), 32'h114, 1'b1, 5'd10, 32'h5d);
        addRow(rFormat(7'h20, 5'd2, 5'd1, 3'd0, 5'd11), 32'h118, 1'b1, 5'd11, 32'h6b);
        addRow(rFormat(7'h00, 5'd4, 5'd1, 3'd7, 5'd12), 32'h11c, 1'b1, 5'd12, 32'h64);
        addRow(rFormat(7'h00, 5'd3, 5'd2, 3'd6, 5'd13), 32'h120, 1'b1, 5'd13, 32'hfffffffb);
        addRow(rFormat(7'h00, 5'd2, 5'd1, 3'd4, 5'd14), 32'h124, 1'b1, 5'd14, 32'hffffff9d);
        addRow(rFormat(7'h00, 5'd3, 5'd1, 3'd1, 5'd15), 32'h128, 1'b1, 5'd15, 32'h320);
        addRow(rFormat(7'h00, 5'd3, 5'd2, 3'd5, 5'd16), 32'h12c, 1'b1, 5'd16, 32'h1fffffff);
        addRow(rFormat(7'h20, 5'd3, 5'd2, 3'd5, 5'd17), 32'h130, 1'b1, 5'd17, 32'hffffffff);
        addRow(rFormat(7'h00, 5'd1, 5'd2, 3'd2, 5'd18), 32'h134, 1'b1, 5'd18, 32'h1);
        addRow(rFormat(7'h00, 5'd1, 5'd2, 3'd3, 5'd19), 32'h138, 1'b1, 5'd19, 32'h0);
        addRow(rFormat(7'h00, 5'd2, 5'd1, 3'd2, 5'd20), 32'h13c, 1'b1, 5'd20, 32'h0);
        addRow(rFormat(7'h00, 5'd2, 5'd1, 3'd3, 5'd21), 32'h140, 1'b1, 5'd21, 32'h1);
        addRow(iFormat(-1, 5'd1, 3'd4, 5'd22), 32'h144, 1'b1, 5'd22, 32'hffffff9b);
        addRow(iFormat(16, 5'd3, 3'd6, 5'd23), 32'h148, 1'b1, 5'd23, 32'h13);
        addRow(iFormat(240, 5'd2, 3'd7, 5'd24), 32'h14c, 1'b1, 5'd24, 32'hf0);
        addRow(iFormat(4, 5'd3, 3'd1, 5'd25), 32'h150, 1'b1, 5'd25, 32'h30);
        addRow(iFormat(1, 5'd2, 3'd5, 5'd26), 32'h154, 1'b1, 5'd26, 32'h7ffffffc);
        addRow(iFormat('h401, 5'd2, 3'd5, 5'd27), 32'h158, 1'b1, 5'd27, 32'hfffffffc);
        addRow(iFormat(-6, 5'd2, 3'd2, 5'd28), 32'h15c, 1'b1, 5'd28, 32'h1);
        addRow(iFormat(-1, 5'd1, 3'd3, 5'd29), 32'h160, 1'b1, 5'd29, 32'h1);
        addRow(iFormat(50, 5'd1, 3'd2, 5'd30), 32'h164, 1'b1, 5'd30, 32'h0);
        // Dependent pairs, then a write to x0
        addRow(iFormat(20, 5'd1, 3'd0, 5'd5), 32'h168, 1'b1, 5'd5, 32'h78);
        addRow(rFormat(7'h00, 5'd5, 5'd5, 3'd0, 5'd6), 32'h16c, 1'b1, 5'd6, 32'hf0);
        addRow(rFormat(7'h00, 5'd0, 5'd5, 3'd0, 5'd8), 32'h170, 1'b1, 5'd8, 32'h78);
        addRow(iFormat(55, 5'd1, 3'd0, 5'd0), 32'h174, 1'b1, 5'd0, 32'h9b);
        addRow(rFormat(7'h00, 5'd0, 5'd0, 3'd0, 5'd7), 32'h178, 1'b1, 5'd7, 32'h0);
        addRow(rFormat(7'h00, 5'd8, 5'd6, 3'd0, 5'd9), 32'h17c, 1'b1, 5'd9, 32'h168);
        // Branches, taken then not taken
        addRow(bFormat(16, 5'd1, 5'd1, 3'd0), 32'h200, 1'b0, 5'd0, 32'h0, 1'b1, 32'h210);
        addRow(bFormat(16, 5'd3, 5'd1, 3'd0), 32'h204, 1'b0, 5'd0, 32'h0, 1'b0, 32'h214);
        addRow(bFormat(-8, 5'd3, 5'd1, 3'd1), 32'h208, 1'b0, 5'd0, 32'h0, 1'b1, 32'h200);
        addRow(bFormat(-8, 5'd3, 5'd3, 3'd1), 32'h20c, 1'b0, 5'd0, 32'h0, 1'b0, 32'h204);
        addRow(bFormat(32, 5'd1, 5'd2, 3'd4), 32'h210, 1'b0, 5'd0, 32'h0, 1'b1, 32'h230);
        addRow(bFormat(32, 5'd2, 5'd1, 3'd4), 32'h214, 1'b0, 5'd0, 32'h0, 1'b0, 32'h234);
        addRow(bFormat(256, 5'd2, 5'd1, 3'd5), 32'h218, 1'b0, 5'd0, 32'h0, 1'b1, 32'h318);
        addRow(bFormat(256, 5'd1, 5'd2, 3'd5), 32'h21c, 1'b0, 5'd0, 32'h0, 1'b0, 32'h31c);
        addRow(bFormat(-32, 5'd2, 5'd1, 3'd6), 32'h220, 1'b0, 5'd0, 32'h0, 1'b1, 32'h200);
        addRow(bFormat(-32, 5'd1, 5'd2, 3'd6), 32'h224, 1'b0, 5'd0, 32'h0, 1'b0, 32'h204);
        addRow(bFormat(8, 5'd1, 5'd2, 3'd7), 32'h228, 1'b0, 5'd0, 32'h0, 1'b1, 32'h230);
        addRow(bFormat(8, 5'd1, 5'd3, 3'd7), 32'h22c, 1'b0, 5'd0, 32'h0, 1'b0, 32'h234);
        // Jumps link pc + 4, JALR target has bit 0 cleared
        addRow(jFormat(64, 5'd10), 32'h300, 1'b1, 5'd10, 32'h304, 1'b1, 32'h340);
        addRow(iFormat(7, 5'd1, 3'd0, 5'd11, OPC_JALR), 32'h304, 1'b1, 5'd11, 32'h308,
               1'b1, 32'h6a);
        addRow(iFormat(2, 5'd4, 3'd0, 5'd12, OPC_JALR), 32'h308, 1'b1, 5'd12, 32'h30c,
               1'b1, 32'h800);
        addRow(jFormat(-256, 5'd13), 32'h30c, 1'b1, 5'd13, 32'h310, 1'b1, 32'h20c);
        addRow(uFormat(20'habcde, 5'd14, OPC_LUI), 32'h310, 1'b1, 5'd14, 32'habcde000);
        addRow(uFormat(20'h12345, 5'd15, OPC_AUIPC), 32'h314, 1'b1, 5'd15, 32'h12345314);
        addRow(rFormat(7'h00, 5'd15, 5'd14, 3'd0, 5'd17), 32'h318, 1'b1, 5'd17, 32'hbe023314);
        addRow(uFormat(20'hfffff, 5'd16, OPC_AUIPC), 32'h31c, 1'b1, 5'd16, 32'hfffff31c);
    endtask

    task automatic abortRun(string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic checkWord(string name, wordT got, wordT exp);
        if (got !== exp) begin
            abortRun($sformatf("Mismatch at %0d ns: %s got %h expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic checkAddr(string name, regAddrT got, regAddrT exp);
        if (got !== exp) begin
            abortRun($sformatf("Mismatch at %0d ns: %s got %0d expected %0d",
                               $time, name, got, exp));
        end
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        if (got !== exp) begin
            abortRun($sformatf("Mismatch at %0d ns: %s got %b expected %b",
                               $time, name, got, exp));
        end
    endtask

    task automatic verifyOutputs(int n);
        rowT  r;
        logic hasTarget;
        r = rows[n];
        hasTarget = r.instr[6:0] inside {OPC_BRANCH, OPC_JAL, OPC_JALR};
        checkBit($sformatf("row %0d validW", n), validW, 1'b1);
        checkBit($sformatf("row %0d regWriteW", n), regWriteW, r.we);
        checkBit($sformatf("row %0d takenW", n), takenW, r.taken);
        if (r.we) begin                                // rd and result only mean something here
            checkAddr($sformatf("row %0d rdW", n), rdW, r.rd);
            checkWord($sformatf("row %0d resultW", n), resultW, r.result);
        end
        if (hasTarget) begin
            checkWord($sformatf("row %0d targetW", n), targetW, r.target);
        end
    endtask

    initial begin
        int limitNs;
        @(negedge rst);
        limitNs = (rows.size() + 10) * 100;
        #(limitNs);
        abortRun($sformatf("Timeout: outputs never finished within %0d ns", limitNs));
    end

    initial begin
        rst    = 1'b1;
        validD = 1'b0;
        instrD = '0;
        pcD    = '0;
        loadTable();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        // Row i goes in at edge i and comes out two edges later
        for (int i = 0; i < rows.size() + 2; i++) begin
            @(posedge clk);
            if (i < rows.size()) begin
                validD <= 1'b1;
                instrD <= rows[i].instr;
                pcD    <= rows[i].pc;
            end else begin
                validD <= 1'b0;
            end
            @(negedge clk);                            // Outputs settled
            if (i >= 2) begin
                verifyOutputs(i - 2);
            end else begin
                checkBit("validW", validW, 1'b0);
                checkBit("regWriteW", regWriteW, 1'b0);
                checkBit("takenW", takenW, 1'b0);
            end
        end
        @(negedge clk);
        checkBit("validW after last row", validW, 1'b0);
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== src/alu.sv ====
module alu import rvIsaPkg::*, rvCtrlPkg::*; (
    input  aluCtrlE aluctrlE,    // Operation select
    input  wordT    srcA,
    input  wordT    srcB,
    output wordT    aluResultE,
    output logic    condE        // Branch comparison outcome
);

    logic [4:0] shamt;
    wordT       diff;
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = srcB[4:0];  // RV32 shifts use 5 bits
    assign diff       = srcA - srcB;
    assign ltSigned   = $signed(srcA) < $signed(srcB);
    assign ltUnsigned = srcA < srcB;

    always_comb begin
        aluResultE = diff;  // Compares leave the difference
        condE      = 1'b0;
        case (aluctrlE)
            ALU_ADD:  aluResultE = srcA + srcB;
            ALU_SUB:  aluResultE = diff;
            ALU_AND:  aluResultE = srcA & srcB;
            ALU_OR:   aluResultE = srcA | srcB;
            ALU_XOR:  aluResultE = srcA ^ srcB;
            ALU_SLL:  aluResultE = srcA << shamt;
            ALU_SRL:  aluResultE = srcA >> shamt;
            ALU_SRA:  aluResultE = wordT'($signed(srcA) >>> shamt);  // Sign fill
            ALU_SLT:  aluResultE = wordT'(ltSigned);
            ALU_SLTU: aluResultE = wordT'(ltUnsigned);
            ALU_BEQ:  condE = (diff == '0);
            ALU_BNE:  condE = (diff != '0);
            ALU_BLT:  condE = ltSigned;
            ALU_BGE:  condE = !ltSigned;
            ALU_BLTU: condE = ltUnsigned;
            ALU_BGEU: condE = !ltUnsigned;
            default:  condE = 1'b0;
        endcase
    end

endmodule

// ==== src/aludecode.sv ====
module aludecode import rvIsaPkg::*, rvCtrlPkg::*; (
    input  funct3T  funct3D,   // Instruction bits 14:12
    input  logic    funct75D,  // Instruction bit 30
    input  aluOpE   aluopD,    // Class from maindecode
    output aluCtrlE aluctrlD   // Operation for the ALU
);

    always_comb begin
        case (aluopD)
            ALUOP_RTYPE: begin
                case ({funct3D, funct75D})
                    4'b0000: aluctrlD = ALU_ADD;
                    4'b0001: aluctrlD = ALU_SUB;   // Bit 30 set
                    4'b1000: aluctrlD = ALU_XOR;
                    4'b1100: aluctrlD = ALU_OR;
                    4'b1110: aluctrlD = ALU_AND;
                    4'b0010: aluctrlD = ALU_SLL;
                    4'b1010: aluctrlD = ALU_SRL;
                    4'b1011: aluctrlD = ALU_SRA;   // Same funct3 as SRL
                    4'b0100: aluctrlD = ALU_SLT;
                    4'b0110: aluctrlD = ALU_SLTU;
                    default: aluctrlD = ALU_ADD;   // Reserved encodings
                endcase
            end

            ALUOP_ITYPE: begin
                // Bit 30 is part of the immediate here, except for shifts
                case (funct3D)
                    3'b000: aluctrlD = ALU_ADD;    // ADDI
                    3'b100: aluctrlD = ALU_XOR;
                    3'b110: aluctrlD = ALU_OR;
                    3'b111: aluctrlD = ALU_AND;
                    3'b001: aluctrlD = ALU_SLL;    // SLLI
                    3'b101: begin
                        if (funct75D) begin
                            aluctrlD = ALU_SRA;    // SRAI
                        end else begin
                            aluctrlD = ALU_SRL;    // SRLI
                        end
                    end
                    3'b010: aluctrlD = ALU_SLT;
                    3'b011: aluctrlD = ALU_SLTU;
                    default: aluctrlD = ALU_ADD;
                endcase
            end

            ALUOP_BRANCH: begin
                case (funct3D)
                    3'b000: aluctrlD = ALU_BEQ;
                    3'b001: aluctrlD = ALU_BNE;
                    3'b100: aluctrlD = ALU_BLT;
                    3'b101: aluctrlD = ALU_BGE;
                    3'b110: aluctrlD = ALU_BLTU;
                    3'b111: aluctrlD = ALU_BGEU;
                    default: aluctrlD = ALU_ADD;   // 010 and 011 undefined
                endcase
            end

            ALUOP_JALR:    aluctrlD = ALU_ADD;     // rs1 + imm
            ALUOP_ADDONLY: aluctrlD = ALU_ADD;
            default:       aluctrlD = ALU_ADD;
        endcase
    end

endmodule

// ==== src/decexec.sv ====
module decexec import rvIsaPkg::*, rvCtrlPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    validD,     // One strobe per instruction
    input  instrT   instrD,
    input  wordT    pcD,
    output logic    validW,     // Two cycles after validD
    output regAddrT rdW,
    output logic    regWriteW,
    output wordT    resultW,
    output logic    takenW,     // Branch taken or jump
    output wordT    targetW     // Branch or jump destination
);

    opcodeE    opcodeD;
    funct3T    funct3D;
    regAddrT   rs1D, rs2D, rdD;
    aluOpE     aluopD;
    immSrcE    immSrcD;
    resultSrcE resultSrcD;
    aluCtrlE   aluctrlD;
    logic      aluSrcD, regWriteD, branchD, jumpD, fwdA, fwdB;
    wordT      immD, rd1D, rd2D, rs1ValD, rs2ValD;

    logic      validE, aluSrcE, regWriteE, branchE, jumpE, jalrE, auipcE;
    logic      condE, takenE;
    aluCtrlE   aluctrlE;
    resultSrcE resSrcE;
    regAddrT   rdE;
    wordT      pcE, immE, rs1ValE, rs2ValE, srcAE, srcBE, aluResultE;
    wordT      resultE, targetSumE, targetE;

    assign opcodeD = opcodeE'(instrD[6:0]);
    assign rdD     = instrD[11:7];
    assign funct3D = instrD[14:12];
    assign rs1D    = instrD[19:15];
    assign rs2D    = instrD[24:20];

    maindecode u_maindecode (.opcodeD, .aluopD, .immSrcD, .aluSrcD, .resultSrcD,
                             .regWriteD, .branchD, .jumpD);
    aludecode u_aludecode (.funct3D, .funct75D(instrD[30]), .aluopD, .aluctrlD);
    immgen u_immgen (.instrD, .immSrcD, .immD);
    regfile u_regfile (.clk, .rst, .ra1(rs1D), .ra2(rs2D), .rd1(rd1D), .rd2(rd2D),
                       .we(validW && regWriteW), .wa(rdW), .wd(resultW));

    // Result still in execute, not yet in the register file
    assign fwdA    = validE && regWriteE && rdE != '0 && rdE == rs1D;
    assign fwdB    = validE && regWriteE && rdE != '0 && rdE == rs2D;
    assign rs1ValD = fwdA ? resultE : rd1D;
    assign rs2ValD = fwdB ? resultE : rd2D;

    always_ff @(posedge clk) begin
        if (rst) begin
            validE    <= 1'b0;
            regWriteE <= 1'b0;
            branchE   <= 1'b0;
            jumpE     <= 1'b0;
        end else begin
            validE <= validD;
            if (validD) begin
                regWriteE <= regWriteD;
                branchE   <= branchD;
                jumpE     <= jumpD;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (validD) begin                       // Payload only
            pcE      <= pcD;
            immE     <= immD;
            rs1ValE  <= rs1ValD;
            rs2ValE  <= rs2ValD;
            rdE      <= rdD;
            aluctrlE <= aluctrlD;
            resSrcE  <= resultSrcD;
            aluSrcE  <= aluSrcD;
            jalrE    <= (aluopD == ALUOP_JALR);
            auipcE   <= (opcodeD == OPC_AUIPC);
        end
    end

    assign srcAE = auipcE ? pcE : rs1ValE;      // AUIPC adds to pc
    assign srcBE = aluSrcE ? immE : rs2ValE;

    alu u_alu (.aluctrlE, .srcA(srcAE), .srcB(srcBE), .aluResultE, .condE);

    assign targetSumE = (jalrE ? rs1ValE : pcE) + immE;
    assign targetE    = {targetSumE[31:1], targetSumE[0] & ~jalrE};  // JALR clears bit 0
    assign takenE     = (branchE && condE) || jumpE;

    always_comb begin
        case (resSrcE)
            RES_PC4: resultE = pcE + wordT'(4);  // Link value
            RES_IMM: resultE = immE;
            default: resultE = aluResultE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            validW    <= 1'b0;
            regWriteW <= 1'b0;
            takenW    <= 1'b0;
        end else begin
            validW    <= validE;
            regWriteW <= validE && regWriteE;
            takenW    <= validE && takenE;
        end
    end

    always_ff @(posedge clk) begin
        if (validE) begin
            rdW     <= rdE;
            resultW <= resultE;
            targetW <= targetE;
        end
    end

    // Nothing upstream checks the strobed word
    instrKnown: assert property (@(posedge clk) disable iff (rst)
                                 validD |-> !$isunknown({instrD, pcD}))
        else $error("decexec: instruction or pc unknown under validD");
    pcAligned: assert property (@(posedge clk) disable iff (rst) validD |-> pcD[1:0] == '0)
        else $error("decexec: pcD not word aligned");

endmodule

// ==== src/immgen.sv ====
module immgen import rvIsaPkg::*, rvCtrlPkg::*; (
    input  instrT  instrD,   // Full instruction word
    input  immSrcE immSrcD,  // Format from maindecode
    output wordT   immD      // Sign-extended immediate
);

    always_comb begin
        case (immSrcD)
            IMM_I: immD = {{20{instrD[31]}}, instrD[31:20]};
            IMM_S: immD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            // Branch offsets are in halfwords, bit 0 implied
            IMM_B: immD = {{19{instrD[31]}}, instrD[31], instrD[7],
                           instrD[30:25], instrD[11:8], 1'b0};
            IMM_U: immD = {instrD[31:12], 12'b0};  // Upper 20 bits
            IMM_J: immD = {{11{instrD[31]}}, instrD[31], instrD[19:12],
                           instrD[20], instrD[30:21], 1'b0};
            default: immD = '0;
        endcase
    end

endmodule

// ==== src/maindecode.sv ====
module maindecode import rvIsaPkg::*, rvCtrlPkg::*; (
    input  opcodeE    opcodeD,     // Instruction bits 6:0
    output aluOpE     aluopD,      // Class for aludecode
    output immSrcE    immSrcD,     // Immediate format
    output logic      aluSrcD,     // Immediate into srcB
    output resultSrcE resultSrcD,  // Write-back select
    output logic      regWriteD,   // Instruction writes rd
    output logic      branchD,     // Conditional branch
    output logic      jumpD        // JAL or JALR
);

    always_comb begin
        aluopD     = ALUOP_ADDONLY;
        immSrcD    = IMM_I;
        aluSrcD    = 1'b0;
        resultSrcD = RES_ALU;
        regWriteD  = 1'b0;  // Stays low for unknown opcodes
        branchD    = 1'b0;
        jumpD      = 1'b0;
        case (opcodeD)
            OPC_OP: begin
                aluopD    = ALUOP_RTYPE;  // rs1 op rs2
                regWriteD = 1'b1;
            end
            OPC_OPIMM: begin
                aluopD    = ALUOP_ITYPE;
                aluSrcD   = 1'b1;         // rs1 op imm
                regWriteD = 1'b1;
            end
            OPC_BRANCH: begin
                aluopD  = ALUOP_BRANCH;
                immSrcD = IMM_B;          // Offset for the target adder
                branchD = 1'b1;
            end
            OPC_JAL: begin
                immSrcD    = IMM_J;
                resultSrcD = RES_PC4;     // rd gets pc + 4
                regWriteD  = 1'b1;
                jumpD      = 1'b1;
            end
            OPC_JALR: begin
                aluopD     = ALUOP_JALR;
                aluSrcD    = 1'b1;
                resultSrcD = RES_PC4;
                regWriteD  = 1'b1;
                jumpD      = 1'b1;
            end
            OPC_LUI: begin
                immSrcD    = IMM_U;
                resultSrcD = RES_IMM;     // ALU bypassed
                regWriteD  = 1'b1;
            end
            OPC_AUIPC: begin
                immSrcD   = IMM_U;
                aluSrcD   = 1'b1;         // pc + imm, srcA picked in execute
                regWriteD = 1'b1;
            end
            default: regWriteD = 1'b0;
        endcase
    end

endmodule

// ==== src/regfile.sv ====
`include "rv_macros.svh"

module regfile import rvIsaPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  regAddrT ra1,  // Read port A address
    input  regAddrT ra2,  // Read port B address
    output wordT    rd1,
    output wordT    rd2,
    input  logic    we,   // Write enable
    input  regAddrT wa,
    input  wordT    wd
);

    wordT regs [`RV_NREGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin  // x0 is hardwired
            regs[wa] <= wd;
        end
    end

    // Write-first, a same-cycle write shows on the read port
    always_comb begin
        if (ra1 == '0) begin
            rd1 = '0;
        end else if (we && ra1 == wa) begin
            rd1 = wd;
        end else begin
            rd1 = regs[ra1];
        end
        if (ra2 == '0) begin
            rd2 = '0;
        end else if (we && ra2 == wa) begin
            rd2 = wd;
        end else begin
            rd2 = regs[ra2];
        end
    end

endmodule

// ==== src/rvCtrlPkg.sv ====
package rvCtrlPkg;

    // Operation class from maindecode to aludecode
    typedef enum logic [2:0] {
        ALUOP_RTYPE   = 3'b000,  // funct3 plus bit 30
        ALUOP_ITYPE   = 3'b001,  // funct3, bit 30 only for shifts
        ALUOP_ADDONLY = 3'b010,  // JAL, LUI, AUIPC
        ALUOP_BRANCH  = 3'b100,  // Compare select from funct3
        ALUOP_JALR    = 3'b101
    } aluOpE;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_BEQ  = 4'd10,  // Compares from here on
        ALU_BNE  = 4'd11,
        ALU_BLT  = 4'd12,
        ALU_BGE  = 4'd13,
        ALU_BLTU = 4'd14,
        ALU_BGEU = 4'd15
    } aluCtrlE;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} immSrcE;

    typedef enum logic [1:0] {
        RES_ALU,  // ALU output
        RES_PC4,  // Link address
        RES_IMM   // Immediate as is, for LUI
    } resultSrcE;

endpackage

// ==== src/rvIsaPkg.sv ====
`include "rv_macros.svh"

package rvIsaPkg;

    typedef logic [31:0]              instrT;    // Raw instruction word
    typedef logic [`RV_XLEN-1:0]      wordT;     // Data, address or PC
    typedef logic [`RV_REGADDR-1:0]   regAddrT;  // rs1, rs2 or rd index
    typedef logic [2:0]               funct3T;   // Instruction bits 14:12

    // Major opcodes in bits 6:0, only the ones this slice executes
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,  // R-type ALU
        OPC_OPIMM  = 7'b0010011,  // I-type ALU
        OPC_BRANCH = 7'b1100011,  // Conditional branches
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcodeE;

endpackage
